// File: list.f
verilog/packer_pkg.sv
verilog/asym_ram_2p.sv
verilog/sync_fifo_asym.sv
verilog/apb_byte_writer.sv
verilog/apb_word_reader.sv
verilog/byte_packer_top.sv
sim/tb_byte_packer.sv

// File: Makefile
# Verilator build and run for the byte packer

VERILATOR ?= verilator
TOP       ?= tb_byte_packer
RTL_TOP   ?= byte_packer_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS     := $(shell grep '\.sv$$' $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_byte_packer.sv
`default_nettype none

module tb_byte_packer;
  timeunit 1ns;
  timeprecision 1ps;

  // Mirrors the DUT defaults
  localparam int wr_data_w      = 8;
  localparam int rd_data_w      = 16;
  localparam int wr_addr_w      = 7;
  localparam int ratio          = rd_data_w / wr_data_w;
  localparam int depth          = 2 ** wr_addr_w;
  localparam int lvl_w          = packer_pkg::level_w;
  localparam int timeout_cycles = 20;

  logic        clk;
  logic        rst;
  logic        w_psel;
  logic        w_penable;
  logic        w_pwrite;
  logic [3:0]  w_paddr;
  logic [31:0] w_pwdata;
  logic [31:0] w_prdata;
  logic        w_pready;
  logic        w_pslverr;
  logic        r_psel;
  logic        r_penable;
  logic        r_pwrite;
  logic [3:0]  r_paddr;
  logic [31:0] r_prdata;
  logic        r_pready;
  logic        r_pslverr;

  // Bytes accepted but not yet popped, oldest first
  logic [wr_data_w-1:0] model [$];
  int                   mismatches;
  int                   timeouts;
  logic [31:0]          rng;
  logic [31:0]          rd_rng;
  bit                   writes_done;

  byte_packer_top dut (
    .clk      (clk),
    .rst      (rst),
    .w_psel   (w_psel),
    .w_penable(w_penable),
    .w_pwrite (w_pwrite),
    .w_paddr  (w_paddr),
    .w_pwdata (w_pwdata),
    .w_prdata (w_prdata),
    .w_pready (w_pready),
    .w_pslverr(w_pslverr),
    .r_psel   (r_psel),
    .r_penable(r_penable),
    .r_pwrite (r_pwrite),
    .r_paddr  (r_paddr),
    .r_prdata (r_prdata),
    .r_pready (r_pready),
    .r_pslverr(r_pslverr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected status word for a given byte count
  function automatic logic [31:0] status_word(input int n, input bit with_avail);
    logic [31:0] s;
    s = '0;
    s[packer_pkg::status_level_lsb +: lvl_w] = lvl_w'(n);
    s[packer_pkg::status_full_bit] = (n == depth);
    if (with_avail) begin
      s[packer_pkg::status_word_avail_bit] = (n >= ratio);
    end
    return s;
  endfunction

  task automatic check_word(input logic [rd_data_w-1:0] got, input logic [rd_data_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // Producer write, model decides acceptance in the completing cycle
  task automatic apb_write_w(input logic [3:0] addr, input logic [31:0] data,
                             output logic err, output logic exp_ok);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    err    = 1'b0;
    exp_ok = 1'b0;
    @(posedge clk);
    #1;
    w_psel   = 1'b1;
    w_penable = 1'b0;
    w_pwrite = 1'b1;
    w_paddr  = addr;
    w_pwdata = data;
    @(posedge clk);
    #1;
    w_penable = 1'b1;
    while (!done) begin
      #1;
      if (w_pready) begin
        err    = w_pslverr;
        exp_ok = (addr == packer_pkg::reg_data) && (model.size() < depth);
        done   = 1'b1;
      end
      @(posedge clk);
      #1;
      if (!done) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
          $display("ERROR at %0t: producer write never got pready", $time);
          timeouts++;
          done = 1'b1;
        end
      end
    end
    if (exp_ok) begin
      model.push_back(data[wr_data_w-1:0]);
    end
    w_psel    = 1'b0;
    w_penable = 1'b0;
  endtask

  task automatic apb_read_w(input logic [3:0] addr, output logic [31:0] data, output logic err);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    data   = '0;
    err    = 1'b0;
    @(posedge clk);
    #1;
    w_psel    = 1'b1;
    w_penable = 1'b0;
    w_pwrite  = 1'b0;
    w_paddr   = addr;
    @(posedge clk);
    #1;
    w_penable = 1'b1;
    while (!done) begin
      #1;
      if (w_pready) begin
        data = w_prdata;
        err  = w_pslverr;
        done = 1'b1;
      end
      @(posedge clk);
      #1;
      if (!done) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
          $display("ERROR at %0t: producer read never got pready", $time);
          timeouts++;
          done = 1'b1;
        end
      end
    end
    w_psel    = 1'b0;
    w_penable = 1'b0;
  endtask

  // Consumer read; the model loses a word on the first access edge
  task automatic apb_read_r(input logic [3:0] addr, output logic [31:0] data, output logic err,
                            output logic exp_ok, output logic [rd_data_w-1:0] exp_word);
    int cycles;
    bit done;
    bit take;
    cycles   = 0;
    done     = 1'b0;
    take     = 1'b0;
    data     = '0;
    err      = 1'b0;
    exp_word = '0;
    @(posedge clk);
    #1;
    r_psel    = 1'b1;
    r_penable = 1'b0;
    r_pwrite  = 1'b0;
    r_paddr   = addr;
    @(posedge clk);
    #1;
    r_penable = 1'b1;
    while (!done) begin
      #1;
      if (cycles == 0) begin
        take = (addr == packer_pkg::reg_data) && (model.size() >= ratio);
      end
      if (r_pready) begin
        data = r_prdata;
        err  = r_pslverr;
        done = 1'b1;
      end
      @(posedge clk);
      #1;
      if (cycles == 0 && take) begin
        for (int i = 0; i < ratio; i++) begin
          exp_word[i*wr_data_w +: wr_data_w] = model.pop_front();
        end
      end
      if (!done) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
          $display("ERROR at %0t: consumer read never got pready", $time);
          timeouts++;
          done = 1'b1;
        end
      end
    end
    exp_ok    = take || (addr == packer_pkg::reg_status);
    r_psel    = 1'b0;
    r_penable = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] b);
    logic err;
    logic ok;
    apb_write_w(packer_pkg::reg_data, {24'hc3a55a, b}, err, ok);
    check_err(err, !ok, "producer pslverr");
  endtask

  task automatic read_word();
    logic [31:0]          data;
    logic                 err;
    logic                 ok;
    logic [rd_data_w-1:0] exp;
    apb_read_r(packer_pkg::reg_data, data, err, ok, exp);
    check_err(err, !ok, "consumer pslverr");
    check_word(data[rd_data_w-1:0], exp, "popped word");
    check_status(data >> rd_data_w, '0, "prdata above the word");
  endtask

  task automatic status_both();
    logic [31:0]          data;
    logic                 err;
    logic                 ok;
    logic [rd_data_w-1:0] unused_word;
    apb_read_w(packer_pkg::reg_status, data, err);
    check_err(err, 1'b0, "producer status pslverr");
    check_status(data, status_word(model.size(), 1'b0), "producer status");
    apb_read_r(packer_pkg::reg_status, data, err, ok, unused_word);
    check_err(err, 1'b0, "consumer status pslverr");
    check_status(data, status_word(model.size(), 1'b1), "consumer status");
  endtask

  task automatic test_reset_status();
    check_err(w_pready, 1'b1, "producer pready after reset");
    check_err(r_pready, 1'b0, "consumer pready when idle");
    check_err(w_pslverr, 1'b0, "producer pslverr after reset");
    check_err(r_pslverr, 1'b0, "consumer pslverr after reset");
    status_both();
  endtask

  // Level steps 4, 2, 0
  task automatic test_basic_pack();
    write_byte(8'h11);
    write_byte(8'h22);
    write_byte(8'h33);
    write_byte(8'h44);
    status_both();
    read_word();
    status_both();
    read_word();
    status_both();
  endtask

  task automatic test_fill_drain();
    for (int i = 0; i < depth; i++) begin
      write_byte(8'(i * 37 + 5));
    end
    status_both();
    // Refused, level must stay at depth
    write_byte(8'hee);
    status_both();
    for (int i = 0; i < depth / ratio; i++) begin
      read_word();
    end
    status_both();
  endtask

  task automatic test_partial_word();
    write_byte(8'h5a);
    read_word();
    status_both();
    write_byte(8'ha5);
    read_word();
    status_both();
  endtask

  task automatic test_random_traffic();
    writes_done = 1'b0;
    rd_rng      = lcg_next(rng ^ 32'h3c3c_3c3c);
    fork
      begin
        for (int i = 0; i < 300; i++) begin
          rng = lcg_next(rng);
          write_byte(rng[23:16]);
          if (rng[2:0] == 3'd0) begin
            repeat (rng[5:3]) @(posedge clk);
          end
        end
        writes_done = 1'b1;
      end
      begin
        int n;
        n = 0;
        while (!(writes_done && model.size() < ratio) && n < 2000) begin
          rd_rng = lcg_next(rd_rng);
          repeat (rd_rng[20:16] % 24) @(posedge clk);
          read_word();
          n++;
        end
        if (n >= 2000) begin
          $display("ERROR at %0t: consumer loop did not drain the FIFO", $time);
          timeouts++;
        end
      end
    join
    status_both();
  endtask

  initial begin
    rst        = 1'b1;
    w_psel     = 1'b0;
    w_penable  = 1'b0;
    w_pwrite   = 1'b0;
    w_paddr    = '0;
    w_pwdata   = '0;
    r_psel     = 1'b0;
    r_penable  = 1'b0;
    r_pwrite   = 1'b0;
    r_paddr    = '0;
    mismatches = 0;
    timeouts   = 0;
    rng        = 32'hae5b_89b8;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_status();
    test_basic_pack();
    test_fill_drain();
    test_partial_word();
    test_random_traffic();

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/byte_packer_top.sv
`default_nettype none

// Byte writer, asymmetric FIFO and word reader
module byte_packer_top #(
  parameter int wr_data_w = 8,
  parameter int rd_data_w = 16,
  parameter int wr_addr_w = 7
) (
  input  logic                              clk,
  input  logic                              rst,
  // Producer port
  input  logic                              w_psel,
  input  logic                              w_penable,
  input  logic                              w_pwrite,
  input  logic [packer_pkg::apb_addr_w-1:0] w_paddr,
  input  logic [packer_pkg::apb_data_w-1:0] w_pwdata,
  output logic [packer_pkg::apb_data_w-1:0] w_prdata,
  output logic                              w_pready,
  output logic                              w_pslverr,
  // Consumer port
  input  logic                              r_psel,
  input  logic                              r_penable,
  input  logic                              r_pwrite,
  input  logic [packer_pkg::apb_addr_w-1:0] r_paddr,
  output logic [packer_pkg::apb_data_w-1:0] r_prdata,
  output logic                              r_pready,
  output logic                              r_pslverr
);

  logic                           push;
  logic [wr_data_w-1:0]           push_data;
  logic                           pop;
  logic [rd_data_w-1:0]           rd_data;
  logic                           full;
  logic                           word_avail;
  logic [packer_pkg::level_w-1:0] level;

  apb_byte_writer u_writer (
    .clk      (clk),
    .rst      (rst),
    .psel     (w_psel),
    .penable  (w_penable),
    .pwrite   (w_pwrite),
    .paddr    (w_paddr),
    .pwdata   (w_pwdata),
    .full     (full),
    .level    (level),
    .prdata   (w_prdata),
    .pready   (w_pready),
    .pslverr  (w_pslverr),
    .push     (push),
    .push_data(push_data)
  );

  sync_fifo_asym #(
    .wr_data_w(wr_data_w),
    .rd_data_w(rd_data_w),
    .wr_addr_w(wr_addr_w)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .rd_data   (rd_data),
    .full      (full),
    .word_avail(word_avail),
    .level     (level)
  );

  apb_word_reader #(
    .rd_data_w(rd_data_w)
  ) u_reader (
    .clk       (clk),
    .rst       (rst),
    .psel      (r_psel),
    .penable   (r_penable),
    .pwrite    (r_pwrite),
    .paddr     (r_paddr),
    .word_avail(word_avail),
    .level     (level),
    .rd_data   (rd_data),
    .full      (full),
    .prdata    (r_prdata),
    .pready    (r_pready),
    .pslverr   (r_pslverr),
    .pop       (pop)
  );

endmodule

`default_nettype wire

// File: verilog/apb_word_reader.sv
`default_nettype none

// Consumer-side APB slave, one wait state on data reads
module apb_word_reader #(
  parameter int rd_data_w = 16
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [packer_pkg::apb_addr_w-1:0] paddr,
  input  logic                              word_avail,
  input  logic [packer_pkg::level_w-1:0]    level,
  input  logic [rd_data_w-1:0]              rd_data,
  input  logic                              full,
  output logic [packer_pkg::apb_data_w-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              pop
);

  localparam logic st_idle = 1'b0;
  localparam logic st_wait = 1'b1;

  logic state;
  logic access;
  logic data_rd;
  logic status_rd;

  assign access    = psel & penable;
  assign data_rd   = access & ~pwrite & (paddr == packer_pkg::reg_data);
  assign status_rd = access & ~pwrite & (paddr == packer_pkg::reg_status);

  // Pop in the first access cycle, word shows up in the next
  assign pop = data_rd & word_avail & (state == st_idle);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (pop) state <= st_wait;
        // Master holds the access phase, so this edge completes it
        st_wait: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Only a popping data read stalls
  assign pready = (state == st_wait) | (access & ~pop);

  // Writes, unknown offsets and reads with no whole word
  assign pslverr = access & (state == st_idle) & ~pop & ~status_rd;

  always_comb begin
    prdata = '0;
    if (state == st_wait) begin
      prdata[rd_data_w-1:0] = rd_data;
    end else if (status_rd) begin
      prdata[packer_pkg::status_level_lsb +: packer_pkg::level_w] = level;
      prdata[packer_pkg::status_full_bit]       = full;
      prdata[packer_pkg::status_word_avail_bit] = word_avail;
    end
  end

  // One pop per data read, and the read holds its access phase for the word
  a_pop_pulse: assert property (@(posedge clk) disable iff (rst)
    pop |=> !pop && psel && penable)
    else $error("pop not a single pulse inside a held data read");

endmodule

`default_nettype wire

// File: verilog/apb_byte_writer.sv
`default_nettype none

// Producer-side APB slave, zero wait states
module apb_byte_writer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [packer_pkg::apb_addr_w-1:0] paddr,
  input  logic [packer_pkg::apb_data_w-1:0] pwdata,
  input  logic                              full,
  input  logic [packer_pkg::level_w-1:0]    level,
  output logic [packer_pkg::apb_data_w-1:0] prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic                              push,
  output logic [7:0]                        push_data
);

  logic access;
  logic is_data;
  logic is_status;
  logic data_wr;
  logic status_rd;

  // Access phase, which always completes here
  assign access    = psel & penable;
  assign is_data   = (paddr == packer_pkg::reg_data);
  assign is_status = (paddr == packer_pkg::reg_status);
  assign data_wr   = access & pwrite & is_data;
  assign status_rd = access & ~pwrite & is_status;

  assign pready = 1'b1;

  // Byte goes into the FIFO on the completing edge
  assign push      = data_wr & ~full;
  assign push_data = pwdata[7:0];

  // Write while full drops the byte.
  // Status is read-only, data is write-only
  assign pslverr = (data_wr & full) |
                   (access & pwrite & ~is_data) |
                   (access & ~pwrite & ~is_status);

  // Word availability is a consumer-side flag and reads as zero here
  always_comb begin
    prdata = '0;
    if (status_rd) begin
      prdata[packer_pkg::status_level_lsb +: packer_pkg::level_w] = level;
      prdata[packer_pkg::status_full_bit] = full;
    end
  end

  // Access phase must follow a setup phase
  a_enable_needs_sel: assert property (@(posedge clk) disable iff (rst)
    $rose(penable) |-> psel)
    else $error("penable rose without psel");

endmodule

`default_nettype wire

// File: verilog/sync_fifo_asym.sv
`default_nettype none

// Byte-in, word-out synchronous FIFO
module sync_fifo_asym #(
  parameter int wr_data_w = 8,
  parameter int rd_data_w = 16,
  parameter int wr_addr_w = 7,
  localparam int ratio     = rd_data_w / wr_data_w,
  localparam int rd_addr_w = wr_addr_w - $clog2(ratio)
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           push,
  input  logic [wr_data_w-1:0]           push_data,
  input  logic                           pop,
  output logic [rd_data_w-1:0]           rd_data,
  output logic                           full,
  output logic                           word_avail,
  output logic [packer_pkg::level_w-1:0] level
);

  localparam int lvl_w = packer_pkg::level_w;

  // Depth and pop step in byte units
  localparam logic [lvl_w-1:0] depth    = lvl_w'(2 ** wr_addr_w);
  localparam logic [lvl_w-1:0] pop_step = lvl_w'(ratio);

  logic [wr_addr_w-1:0] wr_ptr;
  logic [rd_addr_w-1:0] rd_ptr;

  assign full       = (level == depth);
  // A pop needs a complete word, not just a nonzero level
  assign word_avail = (level >= pop_step);

  // Byte write pointer, wraps with the array
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Word read pointer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Occupancy in bytes
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level <= '0;
    end else begin
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - pop_step;
        2'b11:   level <= level + 1'b1 - pop_step;
        default: level <= level;
      endcase
    end
  end

  asym_ram_2p #(
    .wr_data_w(wr_data_w),
    .rd_data_w(rd_data_w),
    .wr_addr_w(wr_addr_w)
  ) u_ram (
    .clk   (clk),
    .w_en  (push),
    .w_addr(wr_ptr),
    .w_data(push_data),
    .r_en  (pop),
    .r_addr(rd_ptr),
    .r_data(rd_data)
  );

  // The writer is responsible for holding off on full
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push while FIFO full");

  // The reader only pops once a whole word is stored
  a_no_pop_partial: assert property (@(posedge clk) disable iff (rst) pop |-> word_avail)
    else $error("pop without a whole word");

  a_level_bound: assert property (@(posedge clk) disable iff (rst) level <= depth)
    else $error("level above depth");

endmodule

`default_nettype wire

// File: verilog/asym_ram_2p.sv
`default_nettype none

// Narrow write port, wide read port over the same byte array
module asym_ram_2p #(
  parameter int wr_data_w = 8,
  parameter int rd_data_w = 16,
  parameter int wr_addr_w = 7,
  localparam int ratio     = rd_data_w / wr_data_w,
  localparam int sel_w     = $clog2(ratio),
  localparam int rd_addr_w = wr_addr_w - sel_w
) (
  input  logic                 clk,
  input  logic                 w_en,
  input  logic [wr_addr_w-1:0] w_addr,
  input  logic [wr_data_w-1:0] w_data,
  input  logic                 r_en,
  input  logic [rd_addr_w-1:0] r_addr,
  output logic [rd_data_w-1:0] r_data
);

  localparam int depth = 2 ** wr_addr_w;

  logic [wr_data_w-1:0] mem [0:depth-1];

  // Byte-wide write
  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // Word read, lowest byte address lands in the low bits.
  // The output register holds between reads.
  always_ff @(posedge clk) begin
    if (r_en) begin
      for (int i = 0; i < ratio; i++) begin
        r_data[i*wr_data_w +: wr_data_w] <= mem[{r_addr, sel_w'(i)}];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/packer_pkg.sv
`default_nettype none

package packer_pkg;

  // APB bus widths
  localparam int apb_addr_w = 4;
  localparam int apb_data_w = 32;

  // Register map, shared by the writer and reader ports
  localparam logic [apb_addr_w-1:0] reg_data   = 4'h0;
  localparam logic [apb_addr_w-1:0] reg_status = 4'h4;

  // Status word layout
  localparam int status_level_lsb      = 0;
  localparam int status_full_bit       = 16;
  localparam int status_word_avail_bit = 17;

  // Occupancy count, in bytes
  localparam int level_w = 16;

endpackage

`default_nettype wire
